// File: vlog.f
+incdir+hdl
hdl/step_pkg.sv
hdl/dual_port_ram.sv
hdl/pipelined_subtractor.sv
hdl/restoring_divider.sv
hdl/delay_line.sv
hdl/step_calculator.sv
tb/tb_step_calculator.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_step_calculator
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
PASS_MSG  := sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tb_step_calculator.sv
`timescale 1ns/10ps
`include "step_settings.svh"

module tb_step_calculator;

  localparam int CHANNELS       = `STEP_CHANNELS;
  localparam int NUM_FRAMES     = 13;
  localparam int MAX_EXPECTED   = NUM_FRAMES * CHANNELS;
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * (CHANNELS + 64) + 256;

  logic                 CLK = 1'b0;
  logic                 reset_out;
  logic                 din_valid;
  step_pkg::steps_t     completion_steps;
  step_pkg::intensity_t intensity;
  step_pkg::rate_t      update_rate;
  logic                 dout_valid;

  // Reference copy of the per-channel RAM contents.
  step_pkg::intensity_t model_target [CHANNELS] = '{default: '0};
  step_pkg::diff_t      model_diff   [CHANNELS] = '{default: '0};
  step_pkg::diff_t      model_rem    [CHANNELS] = '{default: '0};
  step_pkg::intensity_t frame_data   [CHANNELS];

  step_pkg::rate_t expected_rate [MAX_EXPECTED];  // Expected rates in output order.
  int              exp_wr_ptr = 0;
  int              exp_rd_ptr = 0;
  step_pkg::rate_t exp_head;
  logic            exp_avail;

  logic [31:0] rng_state = 32'd73478;
  int          cycle_count = 0;
  int          run_len = 0;
  int          output_count = 0;
  int          mismatch_count = 0;
  int          other_count = 0;
  logic        frame_started = 1'b0;

  assign exp_head  = expected_rate[exp_rd_ptr];
  assign exp_avail = (exp_rd_ptr < exp_wr_ptr);

  step_calculator u_step_calculator (
    .CLK              (CLK),
    .reset_out        (reset_out),
    .din_valid        (din_valid),
    .completion_steps (completion_steps),
    .intensity        (intensity),
    .update_rate      (update_rate),
    .dout_valid       (dout_valid)
  );

  always #10 CLK = ~CLK;

  function automatic logic [31:0] next_random();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
  endfunction

  function automatic step_pkg::intensity_t random_intensity();
    logic [31:0] r;
    r = next_random();
    return (r[15:0] == 16'd0) ? 16'd1 : r[15:0];  // Zero would look like an unchanged target.
  endfunction

  // A changed target restarts the channel, an unchanged one spreads its remainder.
  task automatic predict_frame(input step_pkg::steps_t steps);
    step_pkg::diff_t d;
    step_pkg::rate_t q;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      if (frame_data[ch] != model_target[ch]) begin
        d = (frame_data[ch] > model_target[ch]) ? frame_data[ch] - model_target[ch]
                                                 : model_target[ch] - frame_data[ch];
        model_target[ch] = frame_data[ch];
        model_diff[ch]   = d;
        model_rem[ch]    = d % steps;
        q = d / steps;
      end else if (model_rem[ch] != 16'd0) begin
        q = model_diff[ch] / steps + 16'd1;
        model_rem[ch] = model_rem[ch] - 16'd1;
      end else begin
        q = model_diff[ch] / steps;
      end
      expected_rate[exp_wr_ptr] = q;
      exp_wr_ptr++;
    end
  endtask

  task automatic drive_frame(input step_pkg::steps_t steps, input bit stray_strobe);
    logic [31:0] r;
    predict_frame(steps);
    @(posedge CLK);
    din_valid        <= 1'b1;
    completion_steps <= steps;
    frame_started    <= 1'b1;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      @(posedge CLK);
      r = next_random();
      intensity        <= frame_data[ch];
      din_valid        <= stray_strobe && (ch == CHANNELS / 2);
      completion_steps <= r[15:0];  // Only the value on the accepted strobe counts.
    end
    @(posedge CLK);
    din_valid <= 1'b0;
    intensity <= '0;
    while (exp_rd_ptr != exp_wr_ptr) begin
      @(posedge CLK);
    end
    repeat (2) @(posedge CLK);
  endtask

  task automatic change_some_channels();
    logic [31:0] r;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      r = next_random();
      if (r[1:0] == 2'd0) begin
        frame_data[ch] = random_intensity();
      end
    end
  endtask

  always @(posedge CLK) begin
    if (dout_valid) begin
      run_len      <= run_len + 1;
      output_count <= output_count + 1;
      if (exp_avail) begin
        exp_rd_ptr <= exp_rd_ptr + 1;
      end
    end else begin
      run_len <= 0;
    end
  end

  a_quiet_before_start : assert property (
    @(posedge CLK) disable iff (reset_out) !frame_started |-> !dout_valid
  ) else begin
    other_count++;
    $display("Output valid was high at %0t before any frame was started.", $time);
  end

  a_output_expected : assert property (
    @(posedge CLK) disable iff (reset_out) dout_valid |-> exp_avail
  ) else begin
    other_count++;
    $display("An extra output appeared at %0t with no rate left to expect.", $time);
  end

  a_rate_value : assert property (
    @(posedge CLK) disable iff (reset_out) (dout_valid && exp_avail) |-> update_rate == exp_head
  ) else begin
    mismatch_count++;
    $display("MISMATCH at %0t: update_rate = %0d, expected %0d", $time,
             $sampled(update_rate), $sampled(exp_head));
  end

  a_burst_length : assert property (
    @(posedge CLK) disable iff (reset_out) $fell(dout_valid) |-> run_len == CHANNELS
  ) else begin
    other_count++;
    $display("A valid burst ending at %0t lasted %0d cycles instead of %0d.",
             $time, $sampled(run_len), CHANNELS);
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("The run timed out after %0d cycles before all frames finished.", cycle_count);
      $display("Errors: %0d mismatches, %0d other failures.", mismatch_count, other_count + 1);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    reset_out        = 1'b1;
    din_valid        = 1'b0;
    completion_steps = '0;
    intensity        = '0;
    repeat (16) @(posedge CLK);
    reset_out <= 1'b0;
    repeat (20) @(posedge CLK);  // Idle stretch with no strobe.

    for (int ch = 0; ch < CHANNELS; ch++) begin
      frame_data[ch] = random_intensity();
    end
    drive_frame(16'd5, 1'b0);
    drive_frame(16'd5, 1'b1);  // Same targets, and a strobe lands mid-run.
    drive_frame(16'd5, 1'b0);

    change_some_channels();
    drive_frame(16'd7, 1'b0);
    repeat (7) begin  // Long enough for every counter to reach zero.
      drive_frame(16'd7, 1'b0);
    end

    for (int ch = 0; ch < CHANNELS; ch++) begin
      frame_data[ch] = random_intensity();
    end
    drive_frame(16'd1, 1'b0);
    drive_frame(16'd1, 1'b0);  // Unchanged targets with one step give the plain difference again.

    repeat (40) @(posedge CLK);
    a_all_outputs : assert (output_count == MAX_EXPECTED) else begin
      other_count++;
      $display("Saw %0d outputs in total where %0d were expected.", output_count, MAX_EXPECTED);
    end

    $display("Errors: %0d mismatches, %0d other failures.", mismatch_count, other_count);
    if (mismatch_count + other_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: hdl/step_calculator.sv
`timescale 1ns/10ps
`include "step_settings.svh"

module step_calculator (
  input  logic                 CLK,
  input  logic                 reset_out,
  input  logic                 din_valid,
  input  step_pkg::steps_t     completion_steps,
  input  step_pkg::intensity_t intensity,
  output step_pkg::rate_t      update_rate,
  output logic                 dout_valid
);

  localparam int CHANNELS = `STEP_CHANNELS;
  localparam int WR_OFS   = 1 + `ADDSUB_LATENCY;  // Count at which channel 0 is written back.
  localparam int OUT_OFS  = WR_OFS + `DIV_LATENCY;
  localparam int END_CNT  = OUT_OFS + CHANNELS;

  step_pkg::calc_state_t state;
  logic [`STEP_ADDR_WIDTH:0] cnt;  // Cycles since the frame started.

  step_pkg::steps_t steps_reg;
  step_pkg::addr_t  tgt_rd_addr;
  step_pkg::addr_t  diff_rd_addr;
  step_pkg::addr_t  tbl_wr_addr;
  step_pkg::addr_t  rem_rd_addr;
  step_pkg::addr_t  rem_wr_addr;

  step_pkg::intensity_t target_rd;
  step_pkg::diff_t      diff_rd;
  step_pkg::diff_t      rem_rd;
  step_pkg::intensity_t intensity_rd;
  step_pkg::intensity_t intensity_wr;

  step_pkg::diff_t sub_a;
  step_pkg::diff_t sub_b;
  step_pkg::diff_t sub_diff;
  step_pkg::diff_t div_dividend;
  step_pkg::rate_t div_quotient;
  step_pkg::diff_t div_remainder;
  step_pkg::diff_t rem_next;

  logic run;
  logic start;
  logic wr_window;
  logic out_window;
  logic changed;
  logic changed_d;
  logic tbl_wr_en;

  assign run        = (state == step_pkg::CALC_RUN);
  assign start      = (state == step_pkg::CALC_IDLE) && din_valid;
  assign wr_window  = run && (cnt >= WR_OFS) && (cnt < WR_OFS + CHANNELS);
  assign out_window = run && (cnt >= OUT_OFS) && (cnt < END_CNT);

  assign changed   = (sub_diff != '0);
  assign tbl_wr_en = wr_window && changed;
  assign div_dividend = changed ? sub_diff : diff_rd;

  always_comb begin
    if (intensity_rd < target_rd) begin
      sub_a = target_rd;
      sub_b = intensity_rd;
    end else begin
      sub_a = intensity_rd;
      sub_b = target_rd;
    end
  end

  dual_port_ram u_target_ram (
    .CLK     (CLK),
    .rd_addr (tgt_rd_addr),
    .rd_data (target_rd),
    .wr_en   (tbl_wr_en),
    .wr_addr (tbl_wr_addr),
    .wr_data (intensity_wr)
  );

  dual_port_ram u_diff_ram (
    .CLK     (CLK),
    .rd_addr (diff_rd_addr),
    .rd_data (diff_rd),
    .wr_en   (tbl_wr_en),
    .wr_addr (tbl_wr_addr),
    .wr_data (sub_diff)
  );

  dual_port_ram u_rem_ram (
    .CLK     (CLK),
    .rd_addr (rem_rd_addr),
    .rd_data (rem_rd),
    .wr_en   (dout_valid),
    .wr_addr (rem_wr_addr),
    .wr_data (rem_next)
  );

  pipelined_subtractor u_subtractor (
    .CLK        (CLK),
    .minuend    (sub_a),
    .subtrahend (sub_b),
    .difference (sub_diff)
  );

  restoring_divider u_divider (
    .CLK       (CLK),
    .dividend  (div_dividend),
    .divisor   (steps_reg),
    .quotient  (div_quotient),
    .remainder (div_remainder)
  );

  delay_line #(.WIDTH(`STEP_WIDTH), .DEPTH(1)) u_intensity_rd_dly (
    .CLK  (CLK),
    .din  (intensity),
    .dout (intensity_rd)
  );

  delay_line #(.WIDTH(`STEP_WIDTH), .DEPTH(WR_OFS)) u_intensity_wr_dly (
    .CLK  (CLK),
    .din  (intensity),
    .dout (intensity_wr)
  );

  delay_line #(.WIDTH(1), .DEPTH(`DIV_LATENCY)) u_changed_dly (
    .CLK  (CLK),
    .din  (changed),
    .dout (changed_d)
  );

  always_ff @(posedge CLK) begin
    if (start) begin
      steps_reg <= completion_steps;
    end
  end

  // Each port counter starts behind by its pipeline offset and wraps into channel 0.
  always_ff @(posedge CLK) begin
    if (reset_out) begin
      state        <= step_pkg::CALC_IDLE;
      cnt          <= '0;
      dout_valid   <= 1'b0;
      tgt_rd_addr  <= '0;
      diff_rd_addr <= '0;
      tbl_wr_addr  <= '0;
      rem_rd_addr  <= '0;
      rem_wr_addr  <= '0;
    end else begin
      case (state)
        step_pkg::CALC_IDLE: begin
          dout_valid <= 1'b0;
          if (din_valid) begin
            state        <= step_pkg::CALC_RUN;
            cnt          <= '0;
            tgt_rd_addr  <= '0;
            diff_rd_addr <= step_pkg::addr_t'(1 - WR_OFS);
            tbl_wr_addr  <= step_pkg::addr_t'(-WR_OFS);
            rem_rd_addr  <= step_pkg::addr_t'(1 - OUT_OFS);
            rem_wr_addr  <= step_pkg::addr_t'(-(OUT_OFS + 1));
          end
        end
        step_pkg::CALC_RUN: begin
          cnt          <= cnt + 1'b1;
          tgt_rd_addr  <= tgt_rd_addr + step_pkg::addr_t'(1);
          diff_rd_addr <= diff_rd_addr + step_pkg::addr_t'(1);
          tbl_wr_addr  <= tbl_wr_addr + step_pkg::addr_t'(1);
          rem_rd_addr  <= rem_rd_addr + step_pkg::addr_t'(1);
          rem_wr_addr  <= rem_wr_addr + step_pkg::addr_t'(1);
          dout_valid   <= out_window;
          if (cnt == END_CNT) begin  // The last output is on the bus this cycle.
            state <= step_pkg::CALC_IDLE;
          end
        end
        default: begin
          state <= step_pkg::CALC_IDLE;
        end
      endcase
    end
  end

  // A fresh target restarts the countdown, otherwise the spare remainder is spread out.
  always_ff @(posedge CLK) begin
    if (out_window) begin
      if (changed_d) begin
        update_rate <= div_quotient;
        rem_next    <= div_remainder;
      end else if (rem_rd != '0) begin
        update_rate <= div_quotient + 1'b1;
        rem_next    <= rem_rd - 1'b1;
      end else begin
        update_rate <= div_quotient;
        rem_next    <= '0;
      end
    end
  end

  a_idle_quiet : assert property (
    @(posedge CLK) (state == step_pkg::CALC_IDLE) |-> !dout_valid
  ) else $error("Output valid was raised while the controller was idle.");

  a_reset_clear : assert property (
    @(posedge CLK) reset_out |=> !dout_valid
  ) else $error("Output valid was high in the cycle after reset.");

endmodule

// File: hdl/delay_line.sv
`timescale 1ns/10ps

module delay_line #(
  parameter int WIDTH = 16,
  parameter int DEPTH = 1
) (
  input  logic             CLK,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  logic [WIDTH-1:0] stages [DEPTH];

  always_ff @(posedge CLK) begin
    stages[0] <= din;
    for (int i = 1; i < DEPTH; i++) begin
      stages[i] <= stages[i-1];
    end
  end

  assign dout = stages[DEPTH-1];  // Input from DEPTH cycles ago.

endmodule

// File: hdl/restoring_divider.sv
`timescale 1ns/10ps
`include "step_settings.svh"

module restoring_divider (
  input  logic             CLK,
  input  step_pkg::diff_t  dividend,
  input  step_pkg::steps_t divisor,
  output step_pkg::rate_t  quotient,
  output step_pkg::diff_t  remainder
);

  localparam int W = `STEP_WIDTH;

  // Stage i holds the partial remainder after i quotient bits.
  step_pkg::diff_t  part_rem [W+1];
  // Unused dividend bits sit at the top; quotient bits shift in from the bottom.
  logic [W-1:0]     num_bits [W+1];
  step_pkg::steps_t den      [W];

  always_ff @(posedge CLK) begin
    logic [W:0] shifted;
    logic [W:0] trial;

    part_rem[0] <= '0;
    num_bits[0] <= dividend;
    den[0]      <= divisor;

    for (int i = 0; i < W; i++) begin
      shifted = {part_rem[i], num_bits[i][W-1]};
      trial   = shifted - {1'b0, den[i]};
      if (!trial[W]) begin  // Trial subtraction fits, so keep it and set the bit.
        part_rem[i+1] <= trial[W-1:0];
        num_bits[i+1] <= {num_bits[i][W-2:0], 1'b1};
      end else begin
        part_rem[i+1] <= shifted[W-1:0];
        num_bits[i+1] <= {num_bits[i][W-2:0], 1'b0};
      end
    end

    for (int i = 1; i < W; i++) begin
      den[i] <= den[i-1];
    end

    // A zero divisor makes every trial succeed, giving all ones and the dividend back.
    quotient  <= num_bits[W];
    remainder <= part_rem[W];
  end

  // Known operands must come out as a known result after the full pipeline.
  a_result_known : assert property (
    @(posedge CLK) !$isunknown({dividend, divisor}) |->
      ##(`DIV_LATENCY) !$isunknown({quotient, remainder})
  ) else $error("Divider produced an unknown result from known operands.");

endmodule

// File: hdl/pipelined_subtractor.sv
`timescale 1ns/10ps

module pipelined_subtractor (
  input  logic            CLK,
  input  step_pkg::diff_t minuend,
  input  step_pkg::diff_t subtrahend,
  output step_pkg::diff_t difference
);

  step_pkg::diff_t minuend_q;
  step_pkg::diff_t subtrahend_q;

  // First stage holds the operands.
  always_ff @(posedge CLK) begin
    minuend_q    <= minuend;
    subtrahend_q <= subtrahend;
  end

  // The caller puts the larger value first, so this never wraps.
  always_ff @(posedge CLK) begin
    difference <= minuend_q - subtrahend_q;
  end

endmodule

// File: hdl/dual_port_ram.sv
`timescale 1ns/10ps
`include "step_settings.svh"

module dual_port_ram (
  input  logic                   CLK,
  input  step_pkg::addr_t        rd_addr,
  output logic [`STEP_WIDTH-1:0] rd_data,
  input  logic                   wr_en,
  input  step_pkg::addr_t        wr_addr,
  input  logic [`STEP_WIDTH-1:0] wr_data
);

  localparam int ENTRIES = 1 << `STEP_ADDR_WIDTH;

  // Every channel starts from a zero target, difference and remainder.
  logic [`STEP_WIDTH-1:0] mem [ENTRIES] = '{default: '0};

  // Read data is registered, so it appears one cycle after the address.
  always_ff @(posedge CLK) begin
    rd_data <= mem[rd_addr];
  end

  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

endmodule

// File: hdl/step_pkg.sv
`include "step_settings.svh"

package step_pkg;

  typedef logic [`STEP_WIDTH-1:0] intensity_t;  // Target intensity of one channel.

  typedef logic [`STEP_WIDTH-1:0] steps_t;  // Frame-wide completion step count.

  typedef logic [`STEP_WIDTH-1:0] rate_t;

  // Absolute difference between two targets, also used for remainders.
  typedef logic [`STEP_WIDTH-1:0] diff_t;

  typedef logic [`STEP_ADDR_WIDTH-1:0] addr_t;  // Channel index into the RAMs.

  typedef enum logic {
    CALC_IDLE,
    CALC_RUN
  } calc_state_t;

endpackage

// File: hdl/step_settings.svh
`ifndef STEP_SETTINGS_SVH
`define STEP_SETTINGS_SVH

// Channels delivered per frame, one per clock.
`define STEP_CHANNELS 249

// Width of intensities, step counts and rates.
`define STEP_WIDTH 16

// Address width of the per-channel RAMs.
`define STEP_ADDR_WIDTH 8

// Operands to registered magnitude difference.
`define ADDSUB_LATENCY 2

// The divider has an input register, one stage per quotient bit and an output register.
`define DIV_LATENCY 18

`endif
